// ==== compile.f ====
verilog/mod_arith_pkg.sv
verilog/mod_inverter.sv
verilog/mod_multiplier.sv
verilog/mod_divider.sv
testbench/tb_clock_gen.sv
testbench/mod_divider_checker.sv
testbench/mod_divider_properties.sv
testbench/tb_mod_divider.sv

// ==== Bender.yml ====
package:
  name: mod_divider

sources:
  - files:
      - verilog/mod_arith_pkg.sv
      - verilog/mod_inverter.sv
      - verilog/mod_multiplier.sv
      - verilog/mod_divider.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/mod_divider_checker.sv
      - testbench/mod_divider_properties.sv
      - testbench/tb_mod_divider.sv

// ==== testbench/tb_mod_divider.sv ====
// Top testbench for mod_divider; all table moduli are prime so expected quotients use Fermat
`default_nettype none

module tb_mod_divider;
  import mod_arith_pkg::*;

  localparam int NUM_FIXED    = 12;
  localparam int NUM_ENTRIES  = 32;
  localparam int RESET_CYCLES = 16;
  // Worst request stays well under 300 cycles including gap and hold
  localparam int CYCLE_LIMIT  = NUM_ENTRIES * 300 + RESET_CYCLES;

  // One table row
  typedef struct packed {
    div_operands_t ops;
    residue_t      expected;
    logic [7:0]    gap;
    logic [7:0]    hold;
  } table_entry_t;

  logic          CLK;
  logic          RST;
  logic          req;
  div_operands_t operands;
  residue_t      exp_quotient;
  logic          ack;
  residue_t      quotient;
  int            error_count;
  int            done_count;
  int            cycle_count;
  int            total_errors;
  int            i;
  logic [31:0]   rng;
  table_entry_t  entries [NUM_ENTRIES];

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  tb_clock_gen clock0 (
    .CLK (CLK),
    .RST (RST)
  );

  mod_divider dut0 (
    .CLK      (CLK),
    .RST      (RST),
    .req      (req),
    .operands (operands),
    .ack      (ack),
    .quotient (quotient)
  );

  mod_divider_checker checker0 (
    .CLK          (CLK),
    .RST          (RST),
    .req          (req),
    .operands     (operands),
    .exp_quotient (exp_quotient),
    .ack          (ack),
    .quotient     (quotient),
    .error_count  (error_count),
    .done_count   (done_count)
  );

  bind mod_divider mod_divider_properties props0 (
    .CLK      (CLK),
    .RST      (RST),
    .req      (req),
    .ack      (ack),
    .quotient (quotient)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // n * d^(m-2) mod m for prime m
  function automatic residue_t fermat_quotient(input residue_t n, input residue_t d,
                                               input residue_t m);
    longint base;
    longint acc;
    longint e;
    base = longint'(d) % longint'(m);
    acc  = 1;
    e    = longint'(m) - 2;
    while (e > 0) begin
      if (e[0]) begin
        acc = (acc * base) % longint'(m);
      end
      base = (base * base) % longint'(m);
      e    = e >> 1;
    end
    return residue_t'((longint'(n) * acc) % longint'(m));
  endfunction

  task automatic set_entry(input int idx, input int n, input int d, input int m,
                           input int q, input int gap, input int hold);
    entries[idx].ops.numerator   = residue_t'(n);
    entries[idx].ops.denominator = residue_t'(d);
    entries[idx].ops.modulus     = residue_t'(m);
    entries[idx].expected        = residue_t'(q);
    entries[idx].gap             = 8'(gap);
    entries[idx].hold            = 8'(hold);
  endtask

  task automatic build_table();
    residue_t m;
    residue_t n;
    residue_t d;
    // Hand-worked rows of num, den, mod, quotient, gap, hold
    set_entry(0, 3, 2, 7, 5, 2, 0);
    set_entry(1, 100, 7, 251, 86, 0, 10);
    set_entry(2, 1, 2, 65521, 32761, 1, 0);
    set_entry(3, 2, 2, 3, 1, 0, 0);
    set_entry(4, 1, 2, 3, 2, 3, 5);
    set_entry(5, 65520, 65520, 65521, 1, 0, 0);
    // Denominator one
    set_entry(6, 65520, 1, 65521, 65520, 0, 12);
    // Numerator zero
    set_entry(7, 0, 5, 251, 0, 2, 0);
    // Denominator is modulus minus one
    set_entry(8, 12345, 65520, 65521, 53176, 0, 0);
    set_entry(9, 250, 250, 251, 1, 1, 3);
    set_entry(10, 3, 65519, 65521, 32759, 0, 0);
    set_entry(11, 0, 65520, 65521, 0, 0, 20);
    // Random rows over the same prime moduli
    rng = 32'h63d6_711a;
    for (int k = NUM_FIXED; k < NUM_ENTRIES; k++) begin
      rng = xorshift32(rng);
      case (rng[1:0])
        2'd0:    m = 16'd3;
        2'd1:    m = 16'd7;
        2'd2:    m = 16'd251;
        default: m = 16'd65521;
      endcase
      rng = xorshift32(rng);
      n   = residue_t'(rng % m);
      rng = xorshift32(rng);
      d   = residue_t'(rng % m);
      if (d == '0) begin
        d = residue_t'(1);
      end
      rng = xorshift32(rng);
      // Half back-to-back and a few long holds
      set_entry(k, n, d, m, fermat_quotient(n, d, m), rng[3] ? 0 : rng[2:0],
                rng[4] ? 15 : 0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Request loop
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    req          <= 1'b0;
    operands     <= '0;
    exp_quotient <= '0;
    build_table();
    do @(posedge CLK); while (RST);
    for (i = 0; i < NUM_ENTRIES; i++) begin
      repeat (entries[i].gap) @(posedge CLK);
      @(posedge CLK);
      req          <= 1'b1;
      operands     <= entries[i].ops;
      exp_quotient <= entries[i].expected;
      do @(posedge CLK); while (!ack);
      // Caller back-pressure
      repeat (entries[i].hold) @(posedge CLK);
      req <= 1'b0;
      do @(posedge CLK); while (ack);
    end
    repeat (2) @(posedge CLK);
    total_errors = error_count + dut0.props0.assert_errors;
    if (done_count != NUM_ENTRIES) begin
      $display("Only %0d of %0d requests were answered", done_count, NUM_ENTRIES);
      total_errors = total_errors + 1;
    end
    $display("Errors: checker %0d, assertions %0d, total %0d",
             error_count, dut0.props0.assert_errors, total_errors);
    if (total_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Hang guard
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge CLK);
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
        $display("Timeout: a request never completed within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/mod_divider_properties.sv ====
// Four-phase handshake rules on the divider ports; bound into mod_divider, sampled on CLK
`default_nettype none

module mod_divider_properties (
  input logic                    CLK,
  input logic                    RST,
  input logic                    req,
  input logic                    ack,
  input mod_arith_pkg::residue_t quotient
);

  // Failed assertions, read back at the end of the run
  int assert_errors = 0;

  // Ack rises only for a pending req
  ack_rise_with_req: assert property (@(posedge CLK) disable iff (RST) $rose(ack) |-> req)
    else begin
      $error("ack rose while req was low");
      assert_errors = assert_errors + 1;
    end

  // Ack drops only once req was seen low
  ack_fall_after_req: assert property (@(posedge CLK) disable iff (RST) $fell(ack) |-> !$past(req))
    else begin
      $error("ack fell while req was still high");
      assert_errors = assert_errors + 1;
    end

  // Held answer
  quotient_held: assert property (@(posedge CLK) disable iff (RST)
                                  (ack && $past(ack)) |-> $stable(quotient))
    else begin
      $error("quotient changed while ack was high");
      assert_errors = assert_errors + 1;
    end

  // No stray ack out of reset
  ack_low_after_reset: assert property (@(posedge CLK) $fell(RST) |-> !ack)
    else begin
      $error("ack high in the cycle after reset release");
      assert_errors = assert_errors + 1;
    end

endmodule

`default_nettype wire

// ==== testbench/mod_divider_checker.sv ====
// Checks each answer against the expected quotient and the field identity; moduli must be prime
`default_nettype none

module mod_divider_checker (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         req,
  input  mod_arith_pkg::div_operands_t operands,
  input  mod_arith_pkg::residue_t      exp_quotient,
  input  logic                         ack,
  input  mod_arith_pkg::residue_t      quotient,
  output int                           error_count,
  output int                           done_count
);
  import mod_arith_pkg::*;

  // Request captured when req rose
  div_operands_t ops_q;
  residue_t      exp_q;
  logic          req_d;
  logic          ack_d;
  logic          pending;

  ////////////////////////////////////////////////////////////////////////////
  // Result comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_result();
    longint back;
    // Quotient times denominator should give the numerator back
    back = (longint'(quotient) * longint'(ops_q.denominator)) % longint'(ops_q.modulus);
    if (quotient >= ops_q.modulus) begin
      $display("Mismatch quotient: 0x%h not below modulus 0x%h", quotient, ops_q.modulus);
      error_count = error_count + 1;
    end
    if (quotient !== exp_q) begin
      $display("Mismatch quotient: got 0x%h expected 0x%h (num 0x%h den 0x%h mod 0x%h)",
               quotient, exp_q, ops_q.numerator, ops_q.denominator, ops_q.modulus);
      error_count = error_count + 1;
    end
    if (residue_t'(back) !== ops_q.numerator) begin
      $display("Mismatch quotient*denominator: got 0x%h expected 0x%h (mod 0x%h)",
               residue_t'(back), ops_q.numerator, ops_q.modulus);
      error_count = error_count + 1;
    end
    done_count = done_count + 1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Handshake watch
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (RST) begin
      error_count = 0;
      done_count  = 0;
      req_d       = 1'b0;
      ack_d       = 1'b0;
      pending     = 1'b0;
    end else begin
      // New request
      if (req && !req_d) begin
        ops_q   = operands;
        exp_q   = exp_quotient;
        pending = 1'b1;
      end
      // Quotient loads with the rise of ack
      if (ack && !ack_d) begin
        if (!pending) begin
          $display("Ack rose with no request outstanding");
          error_count = error_count + 1;
        end else begin
          check_result();
        end
        pending = 1'b0;
      end
      req_d = req;
      ack_d = ack;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Free-running clock, period 10; RST high from time zero for 16 rising edges, then held low
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  localparam int RESET_CYCLES = 16;

  // Half period of 5
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Release on a rising edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== verilog/mod_divider.sv ====
// Four-phase req/ack modular divider; one request at a time, no check for a non-invertible denominator
`default_nettype none

module mod_divider (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         req,
  input  mod_arith_pkg::div_operands_t operands,
  output logic                         ack,
  output mod_arith_pkg::residue_t      quotient
);
  import mod_arith_pkg::*;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_INVERT,
    SEQ_MULTIPLY,
    SEQ_DONE,
    SEQ_RELEASE
  } seq_state_t;

  seq_state_t    state;
  div_operands_t ops_q;

  logic     inv_start;
  logic     inv_ready;
  residue_t inverse;
  logic     mul_start;
  logic     mul_ready;
  residue_t product;

  ////////////////////////////////////////////////////////////////////////////
  // Engines
  ////////////////////////////////////////////////////////////////////////////

  // Inverse of the denominator
  mod_inverter inverter0 (
    .CLK     (CLK),
    .RST     (RST),
    .start   (inv_start),
    .value   (ops_q.denominator),
    .modulus (ops_q.modulus),
    .ready   (inv_ready),
    .inverse (inverse)
  );

  // Inverse times numerator
  mod_multiplier multiplier0 (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .a       (inverse),
    .b       (ops_q.numerator),
    .modulus (ops_q.modulus),
    .ready   (mul_ready),
    .product (product)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= SEQ_IDLE;
      ack       <= 1'b0;
      inv_start <= 1'b0;
      mul_start <= 1'b0;
    end else begin
      // Start strobes last one cycle
      inv_start <= 1'b0;
      mul_start <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          // Ack already low here, so req high means a new request
          if (req) begin
            inv_start <= 1'b1;
            state     <= SEQ_INVERT;
          end
        end
        SEQ_INVERT: begin
          if (inv_ready) begin
            mul_start <= 1'b1;
            state     <= SEQ_MULTIPLY;
          end
        end
        SEQ_MULTIPLY: begin
          if (mul_ready) begin
            state <= SEQ_DONE;
          end
        end
        SEQ_DONE: begin
          // Quotient loads on this same edge
          ack   <= 1'b1;
          state <= SEQ_RELEASE;
        end
        SEQ_RELEASE: begin
          // Hold ack until the caller drops req
          if (!req) begin
            ack   <= 1'b0;
            state <= SEQ_IDLE;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  // Operand latch and result register
  always_ff @(posedge CLK) begin
    if (state == SEQ_IDLE && req) begin
      ops_q <= operands;
    end
    if (state == SEQ_DONE) begin
      quotient <= product;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mod_multiplier.sv ====
// MSB-first shift-and-add modular product; a and b must be below modulus, ready DATA_W+1 after start
`default_nettype none

module mod_multiplier (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  mod_arith_pkg::residue_t a,
  input  mod_arith_pkg::residue_t b,
  input  mod_arith_pkg::residue_t modulus,
  output logic                    ready,
  output mod_arith_pkg::residue_t product
);
  import mod_arith_pkg::*;

  typedef enum logic {
    MUL_IDLE,
    MUL_RUN
  } mul_state_t;

  mul_state_t state;
  bit_cnt_t   cnt;

  // Operands captured at start
  residue_t a_q;
  residue_t b_q;
  residue_t m_q;

  wide_t acc;
  wide_t mod_w;
  wide_t dbl;
  wide_t dbl_red;
  wide_t sum;
  wide_t sum_red;

  ////////////////////////////////////////////////////////////////////////////
  // One scan step
  ////////////////////////////////////////////////////////////////////////////

  assign mod_w = {1'b0, m_q};

  // Accumulator below modulus, so doubling fits the guard bit
  assign dbl     = {acc[DATA_W-1:0], 1'b0};
  assign dbl_red = (dbl >= mod_w) ? (dbl - mod_w) : dbl;

  // Add a for a set bit, then reduce once more
  assign sum     = dbl_red + (b_q[DATA_W-1] ? {1'b0, a_q} : '0);
  assign sum_red = (sum >= mod_w) ? (sum - mod_w) : sum;

  // Control and bit counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= MUL_IDLE;
      cnt   <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        MUL_IDLE: begin
          if (start) begin
            cnt   <= bit_cnt_t'(DATA_W - 1);
            state <= MUL_RUN;
          end
        end
        MUL_RUN: begin
          if (cnt == '0) begin
            ready <= 1'b1;
            state <= MUL_IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          state <= MUL_IDLE;
        end
      endcase
    end
  end

  // Accumulator and operand shift
  always_ff @(posedge CLK) begin
    if (state == MUL_IDLE) begin
      if (start) begin
        a_q <= a;
        b_q <= b;
        m_q <= modulus;
        acc <= '0;
      end
    end else begin
      acc <= sum_red;
      b_q <= b_q << 1;
      // Last bit, product held until the next pass ends
      if (cnt == '0) begin
        product <= sum_red[DATA_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mod_inverter.sv ====
// Binary extended Euclid inverse; needs odd modulus > 2 and value coprime to it, else may hang
`default_nettype none

module mod_inverter (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  mod_arith_pkg::residue_t value,
  input  mod_arith_pkg::residue_t modulus,
  output logic                    ready,
  output mod_arith_pkg::residue_t inverse
);
  import mod_arith_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    INV_IDLE,
    INV_TEST,
    INV_HALVE_U,
    INV_HALVE_V,
    INV_SUBTRACT
  } inv_state_t;

  inv_state_t state;

  // Invariants x*value == u and y*value == v, modulo modulus
  wide_t u;
  wide_t v;
  wide_t x;
  wide_t y;

  wide_t mod_w;
  wide_t x_adj;
  wide_t y_adj;
  wide_t x_sub;
  wide_t y_sub;
  logic  u_one;
  logic  v_one;
  logic  x_red;
  logic  y_red;

  ////////////////////////////////////////////////////////////////////////////
  // Next values
  ////////////////////////////////////////////////////////////////////////////

  assign mod_w = {1'b0, modulus};

  // End of search
  assign u_one = (u == wide_t'(1));
  assign v_one = (v == wide_t'(1));

  // Coefficient already below modulus
  assign x_red = (x < mod_w);
  assign y_red = (y < mod_w);

  // Make odd coefficient even before halving
  // Sum stays below 2*modulus, guard bit holds it
  assign x_adj = x[0] ? (x + mod_w) : x;
  assign y_adj = y[0] ? (y + mod_w) : y;

  // Coefficient difference kept in range
  assign x_sub = (x >= y) ? (x - y) : (x + mod_w - y);
  assign y_sub = (y >= x) ? (y - x) : (y + mod_w - x);

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= INV_IDLE;
      ready <= 1'b0;
    end else begin
      // Single cycle pulse
      ready <= 1'b0;
      case (state)
        INV_IDLE: begin
          if (start) begin
            state <= INV_TEST;
          end
        end
        INV_TEST: begin
          // Ender: pick the next reduction step
          if (u_one) begin
            if (x_red) begin
              ready <= 1'b1;
              state <= INV_IDLE;
            end
          end else if (v_one) begin
            if (y_red) begin
              ready <= 1'b1;
              state <= INV_IDLE;
            end
          end else if (!u[0]) begin
            state <= INV_HALVE_U;
          end else if (!v[0]) begin
            state <= INV_HALVE_V;
          end else begin
            state <= INV_SUBTRACT;
          end
        end
        INV_HALVE_U: begin
          // v untouched here
          state <= v[0] ? INV_SUBTRACT : INV_HALVE_V;
        end
        INV_HALVE_V: begin
          state <= INV_SUBTRACT;
        end
        INV_SUBTRACT: begin
          state <= INV_TEST;
        end
        default: begin
          state <= INV_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      INV_IDLE: begin
        if (start) begin
          u <= {1'b0, value};
          v <= mod_w;
          x <= wide_t'(1);
          y <= '0;
        end
      end
      INV_TEST: begin
        // Final correction or result capture
        if (u_one) begin
          if (x_red) begin
            inverse <= x[DATA_W-1:0];
          end else begin
            x <= x - mod_w;
          end
        end else if (v_one) begin
          if (y_red) begin
            inverse <= y[DATA_W-1:0];
          end else begin
            y <= y - mod_w;
          end
        end
      end
      INV_HALVE_U: begin
        u <= u >> 1;
        x <= x_adj >> 1;
      end
      INV_HALVE_V: begin
        v <= v >> 1;
        y <= y_adj >> 1;
      end
      INV_SUBTRACT: begin
        // Larger minus smaller
        if (u >= v) begin
          u <= u - v;
          x <= x_sub;
        end else begin
          v <= v - u;
          y <= y_sub;
        end
      end
      default: begin
        u <= u;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/mod_arith_pkg.sv ====
// Shared widths and types for the divider; DATA_W fixes every width, moduli must be odd and > 2
`default_nettype none

package mod_arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Operand and modulus width
  localparam int DATA_W = 16;

  // Bit counter width for the multiplier scan
  localparam int CNT_W = $clog2(DATA_W);

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Value already reduced below the modulus
  typedef logic [DATA_W-1:0] residue_t;

  // One guard bit for add before subtract
  typedef logic [DATA_W:0] wide_t;

  // Remaining multiplier steps
  typedef logic [CNT_W-1:0] bit_cnt_t;

  // One division request
  // Numerator in the upper field, modulus in the lower
  typedef struct packed {
    residue_t numerator;
    residue_t denominator;
    residue_t modulus;
  } div_operands_t;

endpackage

`default_nettype wire
